/* core_params.svh */
//--------------------------------------------------------------------------
// core parameters: widths, register count, CSR numbers and the casez
// match patterns for every instruction the pipeline decodes
//--------------------------------------------------------------------------
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

`define CORE_XLEN    32
`define CORE_INST_W  32
`define CORE_NREGS   32
`define CORE_RADDR_W 5

// manager CSRs
`define CORE_CSR_MNGR2PROC 12'hfc0
`define CORE_CSR_PROC2MNGR 12'h7c0

// addi x0, x0, 0 ahead of the generic addi pattern
`define CORE_INST_NOP   32'b000000000000_00000_000_00000_0010011

// reg-reg
`define CORE_INST_ADD   32'b0000000_?????_?????_000_?????_0110011
`define CORE_INST_SUB   32'b0100000_?????_?????_000_?????_0110011
`define CORE_INST_SLL   32'b0000000_?????_?????_001_?????_0110011
`define CORE_INST_SLT   32'b0000000_?????_?????_010_?????_0110011
`define CORE_INST_SLTU  32'b0000000_?????_?????_011_?????_0110011
`define CORE_INST_XOR   32'b0000000_?????_?????_100_?????_0110011
`define CORE_INST_SRL   32'b0000000_?????_?????_101_?????_0110011
`define CORE_INST_SRA   32'b0100000_?????_?????_101_?????_0110011
`define CORE_INST_OR    32'b0000000_?????_?????_110_?????_0110011
`define CORE_INST_AND   32'b0000000_?????_?????_111_?????_0110011

// reg-imm
`define CORE_INST_ADDI  32'b????????????_?????_000_?????_0010011
`define CORE_INST_SLTI  32'b????????????_?????_010_?????_0010011
`define CORE_INST_SLTIU 32'b????????????_?????_011_?????_0010011
`define CORE_INST_XORI  32'b????????????_?????_100_?????_0010011
`define CORE_INST_ORI   32'b????????????_?????_110_?????_0010011
`define CORE_INST_ANDI  32'b????????????_?????_111_?????_0010011
`define CORE_INST_SLLI  32'b0000000_?????_?????_001_?????_0010011
`define CORE_INST_SRLI  32'b0000000_?????_?????_101_?????_0010011
`define CORE_INST_SRAI  32'b0100000_?????_?????_101_?????_0010011
`define CORE_INST_LUI   32'b????????????????????_?????_0110111

// manager access, csrrs rd,csr,x0 and csrrw x0,csr,rs1
`define CORE_INST_CSRR  32'b????????????_00000_010_?????_1110011
`define CORE_INST_CSRW  32'b????????????_?????_001_00000_1110011

`endif

/* core_pkg.sv */
//--------------------------------------------------------------------------
// core types shared by control and datapath
//--------------------------------------------------------------------------
package core_pkg;

  // alu function select
  typedef enum logic [3:0] {
    alu_add  = 4'd0,
    alu_sub  = 4'd1,
    alu_and  = 4'd2,
    alu_or   = 4'd3,
    alu_xor  = 4'd4,
    alu_slt  = 4'd5,
    alu_sltu = 4'd6,
    alu_sra  = 4'd7,
    alu_srl  = 4'd8,
    alu_sll  = 4'd9,
    alu_cp0  = 4'd11,
    alu_cp1  = 4'd12
  } alu_fn_e;

  // second operand source
  typedef enum logic [1:0] {
    op2_imm = 2'd0,
    op2_rf  = 2'd1,
    op2_csr = 2'd2
  } op2_sel_e;

  // i is sign-extended 12 bits, u is the upper 20
  typedef enum logic {
    imm_i = 1'b0,
    imm_u = 1'b1
  } imm_type_e;

  // operand bypass source seen from D
  typedef enum logic [1:0] {
    byp_rf = 2'd0,
    byp_x  = 2'd1,
    byp_m  = 2'd2,
    byp_w  = 2'd3
  } byp_sel_e;

endpackage

/* core_alu.sv */
//--------------------------------------------------------------------------
// integer alu: arithmetic, logic, compare, shift and operand copy
//--------------------------------------------------------------------------
`include "core_params.svh"

module core_alu import core_pkg::*; (
  input  logic [`CORE_XLEN-1:0] in0_i,
  input  logic [`CORE_XLEN-1:0] in1_i,
  input  alu_fn_e               fn_i,
  output logic [`CORE_XLEN-1:0] out_o
);

  logic [4:0] shamt;

  // shifts take only the low 5 bits
  assign shamt = in1_i[4:0];

  always_comb begin
    case (fn_i)
      alu_add:  out_o = in0_i + in1_i;
      alu_sub:  out_o = in0_i - in1_i;
      alu_and:  out_o = in0_i & in1_i;
      alu_or:   out_o = in0_i | in1_i;
      alu_xor:  out_o = in0_i ^ in1_i;
      // compares yield 0 or 1
      alu_slt:  out_o = {{(`CORE_XLEN-1){1'b0}}, $signed(in0_i) < $signed(in1_i)};
      alu_sltu: out_o = {{(`CORE_XLEN-1){1'b0}}, in0_i < in1_i};
      alu_sll:  out_o = in0_i << shamt;
      alu_srl:  out_o = in0_i >> shamt;
      alu_sra:  out_o = $signed(in0_i) >>> shamt;
      // copies for csrw and lui/csrr
      alu_cp0:  out_o = in0_i;
      alu_cp1:  out_o = in1_i;
      default:  out_o = '0;
    endcase
  end

endmodule

/* core_regfile.sv */
//--------------------------------------------------------------------------
// register file, two combinational reads, one write, x0 reads zero
//--------------------------------------------------------------------------
`include "core_params.svh"

module core_regfile (
  input  logic                     clk,
  input  logic [`CORE_RADDR_W-1:0] raddr0_i,
  input  logic [`CORE_RADDR_W-1:0] raddr1_i,
  input  logic [`CORE_RADDR_W-1:0] waddr_i,
  input  logic                     wen_i,
  input  logic [`CORE_XLEN-1:0]    wdata_i,
  output logic [`CORE_XLEN-1:0]    rdata0_o,
  output logic [`CORE_XLEN-1:0]    rdata1_o
);

  logic [`CORE_XLEN-1:0] regs [`CORE_NREGS];

  // x0 hardwired, storage behind it never read
  assign rdata0_o = (raddr0_i == '0) ? '0 : regs[raddr0_i];
  assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];

  always_ff @(posedge clk) begin
    if (wen_i && waddr_i != '0) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // a live write must name a real register
  assert property (@(posedge clk) wen_i |-> !$isunknown(waddr_i));

endmodule

/* core_ctrl.sv */
//--------------------------------------------------------------------------
// pipeline control: decode table, stage valid bits, stall chain,
// bypass selects and the val/rdy handshakes of the three streams
//--------------------------------------------------------------------------
`include "core_params.svh"

module core_ctrl import core_pkg::*; (
  input  logic                     clk,
  input  logic                     reset,
  // instruction stream
  input  logic                     inst_val_i,
  output logic                     inst_rdy_o,
  input  logic [`CORE_INST_W-1:0]  inst_d_i,
  // manager streams
  input  logic                     mngr2proc_val_i,
  output logic                     mngr2proc_rdy_o,
  output logic                     proc2mngr_val_o,
  input  logic                     proc2mngr_rdy_i,
  output logic                     commit_o,
  // datapath controls
  output logic                     reg_en_d_o,
  output logic                     reg_en_x_o,
  output logic                     reg_en_m_o,
  output logic                     reg_en_w_o,
  output op2_sel_e                 op2_sel_d_o,
  output imm_type_e                imm_type_d_o,
  output byp_sel_e                 op1_byp_sel_d_o,
  output byp_sel_e                 op2_byp_sel_d_o,
  output alu_fn_e                  alu_fn_x_o,
  output logic [`CORE_RADDR_W-1:0] rf_waddr_w_o,
  output logic                     rf_wen_w_o
);

  localparam logic n = 1'b0;
  localparam logic y = 1'b1;

  // stage valid bits
  logic val_d;
  logic val_x;
  logic val_m;
  logic val_w;

  // stall origins and per-stage stalls
  logic ostall_d;
  logic ostall_w;
  logic stall_d;
  logic stall_x;
  logic stall_m;
  logic stall_w;

  // per-stage control carried down the pipe
  logic                     rf_wen_x;
  logic                     rf_wen_m;
  logic                     rf_wen_w;
  logic                     csrw_x;
  logic                     csrw_m;
  logic                     csrw_w;
  logic [`CORE_RADDR_W-1:0] rf_waddr_x;
  logic [`CORE_RADDR_W-1:0] rf_waddr_m;

  //--------------------------------------------------------------------------
  // D stage
  //--------------------------------------------------------------------------

  // D loads whenever it is not held, empty or not
  assign reg_en_d_o = !stall_d;
  assign inst_rdy_o = !stall_d;

  always_ff @(posedge clk) begin
    if (reset) begin
      val_d <= 1'b0;
    end else if (reg_en_d_o) begin
      val_d <= inst_val_i;
    end
  end

  // instruction fields
  logic [`CORE_RADDR_W-1:0] rd_d;
  logic [`CORE_RADDR_W-1:0] rs1_d;
  logic [`CORE_RADDR_W-1:0] rs2_d;
  logic [11:0]              csr_d;

  assign rd_d  = inst_d_i[11:7];
  assign rs1_d = inst_d_i[19:15];
  assign rs2_d = inst_d_i[24:20];
  assign csr_d = inst_d_i[31:20];

  // decoded controls
  logic    inst_ok_d;
  logic    rs1_en_d;
  logic    rs2_en_d;
  logic    rf_wen_d;
  logic    csrr_d;
  logic    csrw_d;
  alu_fn_e alu_fn_d;

  task automatic cs(
    input logic      ok,
    input imm_type_e imm,
    input logic      r1,
    input op2_sel_e  op2,
    input logic      r2,
    input alu_fn_e   fn,
    input logic      wen,
    input logic      rd_csr,
    input logic      wr_csr
  );
    inst_ok_d    = ok;
    imm_type_d_o = imm;
    rs1_en_d     = r1;
    op2_sel_d_o  = op2;
    rs2_en_d     = r2;
    alu_fn_d     = fn;
    rf_wen_d     = wen;
    csrr_d       = rd_csr;
    csrw_d       = wr_csr;
  endtask

  always_comb begin
    casez (inst_d_i)
      //                   ok imm    rs1 op2      rs2 fn        wen csrr csrw
      `CORE_INST_NOP   : cs(y, imm_i, n, op2_imm, n, alu_add,  n,  n,   n);
      `CORE_INST_ADD   : cs(y, imm_i, y, op2_rf,  y, alu_add,  y,  n,   n);
      `CORE_INST_SUB   : cs(y, imm_i, y, op2_rf,  y, alu_sub,  y,  n,   n);
      `CORE_INST_AND   : cs(y, imm_i, y, op2_rf,  y, alu_and,  y,  n,   n);
      `CORE_INST_OR    : cs(y, imm_i, y, op2_rf,  y, alu_or,   y,  n,   n);
      `CORE_INST_XOR   : cs(y, imm_i, y, op2_rf,  y, alu_xor,  y,  n,   n);
      `CORE_INST_SLT   : cs(y, imm_i, y, op2_rf,  y, alu_slt,  y,  n,   n);
      `CORE_INST_SLTU  : cs(y, imm_i, y, op2_rf,  y, alu_sltu, y,  n,   n);
      `CORE_INST_SLL   : cs(y, imm_i, y, op2_rf,  y, alu_sll,  y,  n,   n);
      `CORE_INST_SRL   : cs(y, imm_i, y, op2_rf,  y, alu_srl,  y,  n,   n);
      `CORE_INST_SRA   : cs(y, imm_i, y, op2_rf,  y, alu_sra,  y,  n,   n);
      `CORE_INST_ADDI  : cs(y, imm_i, y, op2_imm, n, alu_add,  y,  n,   n);
      `CORE_INST_ANDI  : cs(y, imm_i, y, op2_imm, n, alu_and,  y,  n,   n);
      `CORE_INST_ORI   : cs(y, imm_i, y, op2_imm, n, alu_or,   y,  n,   n);
      `CORE_INST_XORI  : cs(y, imm_i, y, op2_imm, n, alu_xor,  y,  n,   n);
      `CORE_INST_SLTI  : cs(y, imm_i, y, op2_imm, n, alu_slt,  y,  n,   n);
      `CORE_INST_SLTIU : cs(y, imm_i, y, op2_imm, n, alu_sltu, y,  n,   n);
      `CORE_INST_SLLI  : cs(y, imm_i, y, op2_imm, n, alu_sll,  y,  n,   n);
      `CORE_INST_SRLI  : cs(y, imm_i, y, op2_imm, n, alu_srl,  y,  n,   n);
      `CORE_INST_SRAI  : cs(y, imm_i, y, op2_imm, n, alu_sra,  y,  n,   n);
      `CORE_INST_LUI   : cs(y, imm_u, n, op2_imm, n, alu_cp1,  y,  n,   n);
      `CORE_INST_CSRR  : cs(y, imm_i, n, op2_csr, n, alu_cp1,  y,  y,   n);
      `CORE_INST_CSRW  : cs(y, imm_i, y, op2_rf,  n, alu_cp0,  n,  n,   y);
      default          : cs(n, imm_i, n, op2_imm, n, alu_add,  n,  n,   n);
    endcase
    // only the two manager CSRs exist, anything else is undefined
    if ((csrr_d && csr_d != `CORE_CSR_MNGR2PROC) ||
        (csrw_d && csr_d != `CORE_CSR_PROC2MNGR)) begin
      cs(n, imm_i, n, op2_imm, n, alu_add, n, n, n);
    end
  end

  // bypass pick, youngest producer wins, x0 never forwarded
  function automatic byp_sel_e pick_byp(
    input logic                     en,
    input logic [`CORE_RADDR_W-1:0] rs
  );
    byp_sel_e sel;
    sel = byp_rf;
    if (en && rs != '0) begin
      if (val_x && rf_wen_x && rs == rf_waddr_x) sel = byp_x;
      else if (val_m && rf_wen_m && rs == rf_waddr_m) sel = byp_m;
      else if (val_w && rf_wen_w && rs == rf_waddr_w_o) sel = byp_w;
    end
    return sel;
  endfunction

  always_comb begin
    op1_byp_sel_d_o = pick_byp(rs1_en_d, rs1_d);
    op2_byp_sel_d_o = pick_byp(rs2_en_d, rs2_d);
  end

  // csrr waits in D for manager data
  assign ostall_d        = val_d && csrr_d && !mngr2proc_val_i;
  assign stall_d         = val_d && (ostall_d || ostall_w);
  assign mngr2proc_rdy_o = val_d && csrr_d && !stall_d;

  //--------------------------------------------------------------------------
  // X, M and W stages
  //--------------------------------------------------------------------------

  // only W originates a stall behind D
  assign ostall_w = val_w && csrw_w && !proc2mngr_rdy_i;
  assign stall_x  = val_x && ostall_w;
  assign stall_m  = val_m && ostall_w;
  assign stall_w  = ostall_w;

  assign reg_en_x_o = !stall_x;
  assign reg_en_m_o = !stall_m;
  assign reg_en_w_o = !stall_w;

  always_ff @(posedge clk) begin
    if (reset) begin
      val_x    <= 1'b0;
      val_m    <= 1'b0;
      val_w    <= 1'b0;
      rf_wen_x <= 1'b0;
      rf_wen_m <= 1'b0;
      rf_wen_w <= 1'b0;
      csrw_x   <= 1'b0;
      csrw_m   <= 1'b0;
      csrw_w   <= 1'b0;
    end else begin
      // a stalled D sends a bubble into X
      if (reg_en_x_o) begin
        val_x    <= val_d && !stall_d;
        rf_wen_x <= rf_wen_d;
        csrw_x   <= csrw_d;
      end
      if (reg_en_m_o) begin
        val_m    <= val_x && !stall_x;
        rf_wen_m <= rf_wen_x;
        csrw_m   <= csrw_x;
      end
      if (reg_en_w_o) begin
        val_w    <= val_m && !stall_m;
        rf_wen_w <= rf_wen_m;
        csrw_w   <= csrw_m;
      end
    end
  end

  // destination and alu function travel without reset
  always_ff @(posedge clk) begin
    if (reg_en_x_o) begin
      rf_waddr_x <= rd_d;
      alu_fn_x_o <= alu_fn_d;
    end
    if (reg_en_m_o) begin
      rf_waddr_m <= rf_waddr_x;
    end
    if (reg_en_w_o) begin
      rf_waddr_w_o <= rf_waddr_m;
    end
  end

  assign rf_wen_w_o      = val_w && rf_wen_w;
  assign proc2mngr_val_o = val_w && csrw_w;
  assign commit_o        = val_w && !stall_w;

  // undefined words must never sit live in D
  assert property (@(posedge clk) disable iff (reset) val_d |-> inst_ok_d);

  // proc2mngr offer is withdrawn only by a transfer
  assert property (@(posedge clk) disable iff (reset)
    proc2mngr_val_o && !proc2mngr_rdy_i |=> proc2mngr_val_o);

endmodule

/* core_dpath.sv */
//--------------------------------------------------------------------------
// core datapath: stage registers, immediates, bypass and operand muxes
//--------------------------------------------------------------------------
`include "core_params.svh"

module core_dpath import core_pkg::*; (
  input  logic                     clk,
  input  logic [`CORE_INST_W-1:0]  inst_i,
  input  logic [`CORE_XLEN-1:0]    mngr2proc_data_i,
  input  logic                     reg_en_d_i,
  input  logic                     reg_en_x_i,
  input  logic                     reg_en_m_i,
  input  logic                     reg_en_w_i,
  input  op2_sel_e                 op2_sel_d_i,
  input  imm_type_e                imm_type_d_i,
  input  byp_sel_e                 op1_byp_sel_d_i,
  input  byp_sel_e                 op2_byp_sel_d_i,
  input  alu_fn_e                  alu_fn_x_i,
  input  logic [`CORE_RADDR_W-1:0] rf_waddr_w_i,
  input  logic                     rf_wen_w_i,
  output logic [`CORE_INST_W-1:0]  inst_d_o,
  output logic [`CORE_XLEN-1:0]    proc2mngr_data_o
);

  logic [`CORE_XLEN-1:0] rf_rdata0_d;
  logic [`CORE_XLEN-1:0] rf_rdata1_d;
  logic [`CORE_XLEN-1:0] imm_d;
  logic [`CORE_XLEN-1:0] rs1_data_d;
  logic [`CORE_XLEN-1:0] rs2_data_d;
  logic [`CORE_XLEN-1:0] op2_d;
  logic [`CORE_XLEN-1:0] op1_x;
  logic [`CORE_XLEN-1:0] op2_x;
  logic [`CORE_XLEN-1:0] alu_out_x;
  logic [`CORE_XLEN-1:0] result_m;
  logic [`CORE_XLEN-1:0] result_w;

  // one forwarding mux, used for both source operands
  function automatic logic [`CORE_XLEN-1:0] byp_mux(
    input byp_sel_e              sel,
    input logic [`CORE_XLEN-1:0] rf_data,
    input logic [`CORE_XLEN-1:0] x_data,
    input logic [`CORE_XLEN-1:0] m_data,
    input logic [`CORE_XLEN-1:0] w_data
  );
    case (sel)
      byp_x:   return x_data;
      byp_m:   return m_data;
      byp_w:   return w_data;
      default: return rf_data;
    endcase
  endfunction

  //--------------------------------------------------------------------------
  // D stage
  //--------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reg_en_d_i) begin
      inst_d_o <= inst_i;
    end
  end

  core_regfile i_regfile (
    .clk      (clk),
    .raddr0_i (inst_d_o[19:15]),
    .raddr1_i (inst_d_o[24:20]),
    .waddr_i  (rf_waddr_w_i),
    .wen_i    (rf_wen_w_i),
    .wdata_i  (result_w),
    .rdata0_o (rf_rdata0_d),
    .rdata1_o (rf_rdata1_d)
  );

  // shift immediates ride in imm_i, alu uses the low 5 bits
  always_comb begin
    case (imm_type_d_i)
      imm_u:   imm_d = {inst_d_o[31:12], 12'b0};
      default: imm_d = {{20{inst_d_o[31]}}, inst_d_o[31:20]};
    endcase
  end

  assign rs1_data_d = byp_mux(op1_byp_sel_d_i, rf_rdata0_d, alu_out_x, result_m, result_w);
  assign rs2_data_d = byp_mux(op2_byp_sel_d_i, rf_rdata1_d, alu_out_x, result_m, result_w);

  always_comb begin
    case (op2_sel_d_i)
      op2_imm: op2_d = imm_d;
      op2_rf:  op2_d = rs2_data_d;
      default: op2_d = mngr2proc_data_i;
    endcase
  end

  //--------------------------------------------------------------------------
  // X, M and W stages
  //--------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reg_en_x_i) begin
      op1_x <= rs1_data_d;
      op2_x <= op2_d;
    end
    if (reg_en_m_i) begin
      result_m <= alu_out_x;
    end
    if (reg_en_w_i) begin
      result_w <= result_m;
    end
  end

  core_alu i_alu (
    .in0_i (op1_x),
    .in1_i (op2_x),
    .fn_i  (alu_fn_x_i),
    .out_o (alu_out_x)
  );

  // csrw carries rs1 through the cp0 copy
  assign proc2mngr_data_o = result_w;

endmodule

/* core_top.sv */
//--------------------------------------------------------------------------
// four-stage integer core, control and datapath on three val/rdy streams
//--------------------------------------------------------------------------
`include "core_params.svh"

module core_top import core_pkg::*; (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    inst_val_i,
  output logic                    inst_rdy_o,
  input  logic [`CORE_INST_W-1:0] inst_i,
  input  logic                    mngr2proc_val_i,
  output logic                    mngr2proc_rdy_o,
  input  logic [`CORE_XLEN-1:0]   mngr2proc_data_i,
  output logic                    proc2mngr_val_o,
  input  logic                    proc2mngr_rdy_i,
  output logic [`CORE_XLEN-1:0]   proc2mngr_data_o,
  output logic                    commit_o
);

  // ctrl to dpath
  logic                     reg_en_d;
  logic                     reg_en_x;
  logic                     reg_en_m;
  logic                     reg_en_w;
  op2_sel_e                 op2_sel_d;
  imm_type_e                imm_type_d;
  byp_sel_e                 op1_byp_sel_d;
  byp_sel_e                 op2_byp_sel_d;
  alu_fn_e                  alu_fn_x;
  logic [`CORE_RADDR_W-1:0] rf_waddr_w;
  logic                     rf_wen_w;
  // dpath to ctrl
  logic [`CORE_INST_W-1:0]  inst_d;

  core_ctrl i_ctrl (
    .clk             (clk),
    .reset           (reset),
    .inst_val_i      (inst_val_i),
    .inst_rdy_o      (inst_rdy_o),
    .inst_d_i        (inst_d),
    .mngr2proc_val_i (mngr2proc_val_i),
    .mngr2proc_rdy_o (mngr2proc_rdy_o),
    .proc2mngr_val_o (proc2mngr_val_o),
    .proc2mngr_rdy_i (proc2mngr_rdy_i),
    .commit_o        (commit_o),
    .reg_en_d_o      (reg_en_d),
    .reg_en_x_o      (reg_en_x),
    .reg_en_m_o      (reg_en_m),
    .reg_en_w_o      (reg_en_w),
    .op2_sel_d_o     (op2_sel_d),
    .imm_type_d_o    (imm_type_d),
    .op1_byp_sel_d_o (op1_byp_sel_d),
    .op2_byp_sel_d_o (op2_byp_sel_d),
    .alu_fn_x_o      (alu_fn_x),
    .rf_waddr_w_o    (rf_waddr_w),
    .rf_wen_w_o      (rf_wen_w)
  );

  core_dpath i_dpath (
    .clk              (clk),
    .inst_i           (inst_i),
    .mngr2proc_data_i (mngr2proc_data_i),
    .reg_en_d_i       (reg_en_d),
    .reg_en_x_i       (reg_en_x),
    .reg_en_m_i       (reg_en_m),
    .reg_en_w_i       (reg_en_w),
    .op2_sel_d_i      (op2_sel_d),
    .imm_type_d_i     (imm_type_d),
    .op1_byp_sel_d_i  (op1_byp_sel_d),
    .op2_byp_sel_d_i  (op2_byp_sel_d),
    .alu_fn_x_i       (alu_fn_x),
    .rf_waddr_w_i     (rf_waddr_w),
    .rf_wen_w_i       (rf_wen_w),
    .inst_d_o         (inst_d),
    .proc2mngr_data_o (proc2mngr_data_o)
  );

endmodule

/* tb_core.sv */
//--------------------------------------------------------------------------
// testbench for the four-stage core: random programs, reference model,
// val/rdy stream drivers and an in-order proc2mngr checker
//--------------------------------------------------------------------------
`include "core_params.svh"

module tb_core;
  timeunit 1ns;
  timeprecision 1ps;

  // program shape
  localparam int BODY_N = 220;
  localparam int CALM_N = 48;

  typedef enum int {
    op_add, op_sub, op_and, op_or, op_xor, op_slt, op_sltu, op_sll, op_srl, op_sra,
    op_addi, op_andi, op_ori, op_xori, op_slti, op_sltiu, op_slli, op_srli, op_srai,
    op_lui, op_nop, op_csrr, op_csrw
  } op_e;

  logic                    clk;
  logic                    reset;
  logic                    inst_val_i;
  logic                    inst_rdy_o;
  logic [`CORE_INST_W-1:0] inst_i;
  logic                    mngr2proc_val_i;
  logic                    mngr2proc_rdy_o;
  logic [`CORE_XLEN-1:0]   mngr2proc_data_i;
  logic                    proc2mngr_val_o;
  logic                    proc2mngr_rdy_i;
  logic [`CORE_XLEN-1:0]   proc2mngr_data_o;
  logic                    commit_o;

  // program and expected streams
  op_e                   prog_op[$];
  logic [4:0]            prog_rd[$];
  logic [4:0]            prog_rs1[$];
  logic [4:0]            prog_rs2[$];
  logic [`CORE_XLEN-1:0] prog_imm[$];
  logic [31:0]           prog_word[$];
  logic [`CORE_XLEN-1:0] mngr_q[$];
  logic [`CORE_XLEN-1:0] exp_q[$];
  int                    csrw_acc_q[$];
  logic [31:0]           nop_word;

  int n_inst;
  int n_mngr;
  int n_exp;
  int limit = 1000000;
  int cycles = 0;
  int inst_idx = 0;
  int mngr_idx = 0;
  int exp_idx = 0;
  int commits = 0;

  // driver and checker state
  logic                  go;
  logic                  calm;
  logic                  inst_fire;
  logic                  mngr_fire;
  logic                  held = 1'b0;
  logic [`CORE_XLEN-1:0] held_data;
  int                    acc;

  core_top i_dut (
    .clk              (clk),
    .reset            (reset),
    .inst_val_i       (inst_val_i),
    .inst_rdy_o       (inst_rdy_o),
    .inst_i           (inst_i),
    .mngr2proc_val_i  (mngr2proc_val_i),
    .mngr2proc_rdy_o  (mngr2proc_rdy_o),
    .mngr2proc_data_i (mngr2proc_data_i),
    .proc2mngr_val_o  (proc2mngr_val_o),
    .proc2mngr_rdy_i  (proc2mngr_rdy_i),
    .proc2mngr_data_o (proc2mngr_data_o),
    .commit_o         (commit_o)
  );

  always #4 clk = ~clk;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_equal(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("FAILED %s expected 0x%h actual 0x%h", name, exp, act);
      fail_run("value mismatch");
    end
  endtask

  // instruction word from the casez pattern, wildcards become zero
  function automatic logic [31:0] encode(input op_e op, input logic [4:0] rd,
      input logic [4:0] rs1, input logic [4:0] rs2, input logic [31:0] imm);
    logic [31:0] pat;
    logic [31:0] w;
    int i;
    case (op)
      op_add:   pat = `CORE_INST_ADD;
      op_sub:   pat = `CORE_INST_SUB;
      op_and:   pat = `CORE_INST_AND;
      op_or:    pat = `CORE_INST_OR;
      op_xor:   pat = `CORE_INST_XOR;
      op_slt:   pat = `CORE_INST_SLT;
      op_sltu:  pat = `CORE_INST_SLTU;
      op_sll:   pat = `CORE_INST_SLL;
      op_srl:   pat = `CORE_INST_SRL;
      op_sra:   pat = `CORE_INST_SRA;
      op_addi:  pat = `CORE_INST_ADDI;
      op_andi:  pat = `CORE_INST_ANDI;
      op_ori:   pat = `CORE_INST_ORI;
      op_xori:  pat = `CORE_INST_XORI;
      op_slti:  pat = `CORE_INST_SLTI;
      op_sltiu: pat = `CORE_INST_SLTIU;
      op_slli:  pat = `CORE_INST_SLLI;
      op_srli:  pat = `CORE_INST_SRLI;
      op_srai:  pat = `CORE_INST_SRAI;
      op_lui:   pat = `CORE_INST_LUI;
      op_csrr:  pat = `CORE_INST_CSRR;
      op_csrw:  pat = `CORE_INST_CSRW;
      default:  pat = `CORE_INST_NOP;
    endcase
    for (i = 0; i < 32; i++) begin
      w[i] = (pat[i] === 1'b1);
    end
    if (op <= op_sra) begin
      w[24:20] = rs2;
      w[19:15] = rs1;
      w[11:7]  = rd;
    end else if (op <= op_sltiu) begin
      w[31:20] = imm[11:0];
      w[19:15] = rs1;
      w[11:7]  = rd;
    end else if (op <= op_srai) begin
      // shamt field only, funct7 comes from the pattern
      w[24:20] = imm[4:0];
      w[19:15] = rs1;
      w[11:7]  = rd;
    end else if (op == op_lui) begin
      w[31:12] = imm[19:0];
      w[11:7]  = rd;
    end else if (op == op_csrr) begin
      w[31:20] = `CORE_CSR_MNGR2PROC;
      w[11:7]  = rd;
    end else if (op == op_csrw) begin
      w[31:20] = `CORE_CSR_PROC2MNGR;
      w[19:15] = rs1;
    end
    return w;
  endfunction

  // reference result, b is rs2 data or the extended immediate
  function automatic logic [31:0] ref_exec(input op_e op, input logic [31:0] a,
      input logic [31:0] b, input logic [31:0] mngr);
    case (op)
      op_add, op_addi:   return a + b;
      op_sub:            return a - b;
      op_and, op_andi:   return a & b;
      op_or, op_ori:     return a | b;
      op_xor, op_xori:   return a ^ b;
      op_slt, op_slti:   return {31'b0, $signed(a) < $signed(b)};
      op_sltu, op_sltiu: return {31'b0, a < b};
      op_sll, op_slli:   return a << b[4:0];
      op_srl, op_srli:   return a >> b[4:0];
      op_sra, op_srai:   return $signed(a) >>> b[4:0];
      op_lui:            return {b[19:0], 12'b0};
      op_csrr:           return mngr;
      op_csrw:           return a;
      default:           return '0;
    endcase
  endfunction

  task automatic add_inst(input op_e op, input logic [4:0] rd, input logic [4:0] rs1,
      input logic [4:0] rs2, input logic [31:0] imm);
    prog_op.push_back(op);
    prog_rd.push_back(rd);
    prog_rs1.push_back(rs1);
    prog_rs2.push_back(rs2);
    prog_imm.push_back(imm);
    prog_word.push_back(encode(op, rd, rs1, rs2, imm));
  endtask

  // half the sources reuse a destination 1 to 3 back
  function automatic logic [4:0] pick_src();
    if ($urandom % 2 == 0 && prog_rd.size() >= 3) begin
      return prog_rd[prog_rd.size() - 1 - ($urandom % 3)];
    end
    return 5'($urandom % 8);
  endfunction

  task automatic build_program();
    int k;
    int sel;
    op_e op;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [31:0] r;
    logic [31:0] imm;
    // every source register gets a value first
    for (k = 1; k < 8; k++) begin
      r = $urandom;
      if (r[0]) begin
        add_inst(op_addi, 5'(k), 5'd0, 5'd0, {{20{r[15]}}, r[15:4]});
      end else begin
        mngr_q.push_back($urandom);
        add_inst(op_csrr, 5'(k), 5'd0, 5'd0, '0);
      end
    end
    for (k = 0; k < BODY_N; k++) begin
      sel = $urandom % 10;
      r   = $urandom;
      rd  = 5'($urandom % 8);
      rs1 = pick_src();
      rs2 = pick_src();
      imm = '0;
      if (sel < 4) begin
        op = op_e'($urandom % 10);
      end else if (sel < 7) begin
        op  = op_e'(10 + $urandom % 10);
        rs2 = '0;
        if (op == op_lui) imm = {12'b0, r[19:0]};
        else if (op >= op_slli) imm = {27'b0, r[4:0]};
        else imm = {{20{r[11]}}, r[11:0]};
      end else if (sel == 7) begin
        op  = op_csrr;
        rs1 = '0;
        rs2 = '0;
        mngr_q.push_back(r);
      end else if (sel == 8 || $urandom % 3 != 0) begin
        op  = op_csrw;
        rd  = '0;
        rs2 = '0;
      end else begin
        op  = op_nop;
        rd  = '0;
        rs1 = '0;
        rs2 = '0;
      end
      add_inst(op, rd, rs1, rs2, imm);
    end
    // final register dump, x0 included
    for (k = 0; k < 8; k++) begin
      add_inst(op_csrw, 5'd0, 5'(k), 5'd0, '0);
    end
  endtask

  task automatic run_model();
    logic [31:0] mregs [8];
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    int i;
    int m;
    m = 0;
    for (i = 0; i < 8; i++) begin
      mregs[i] = '0;
    end
    for (i = 0; i < prog_op.size(); i++) begin
      a = mregs[prog_rs1[i][2:0]];
      b = (prog_op[i] <= op_sra) ? mregs[prog_rs2[i][2:0]] : prog_imm[i];
      r = ref_exec(prog_op[i], a, b, (prog_op[i] == op_csrr) ? mngr_q[m] : '0);
      if (prog_op[i] == op_csrr) m++;
      if (prog_op[i] == op_csrw) begin
        exp_q.push_back(r);
      end else if (prog_op[i] != op_nop && prog_rd[i] != 0) begin
        mregs[prog_rd[i][2:0]] = r;
      end
    end
  endtask

  //--------------------------------------------------------------------------
  // stream drivers, sample on the edge, drive 1 ns later
  //--------------------------------------------------------------------------

  always @(posedge clk) begin
    go        = !reset;
    inst_fire = inst_val_i && inst_rdy_o;
    mngr_fire = mngr2proc_val_i && mngr2proc_rdy_o;
    if (go) begin
      if (inst_fire) begin
        // accept edge kept for the latency check in the calm part
        if (prog_op[inst_idx] == op_csrw) begin
          csrw_acc_q.push_back((inst_idx < CALM_N) ? cycles : -1);
        end
        inst_idx++;
      end
      if (mngr_fire) mngr_idx++;
      if (commit_o) begin
        commits++;
        if (commits > inst_idx) fail_run("commit seen without a matching accepted instruction");
      end
    end
    #1;
    if (go) begin
      // no gaps and no back-pressure until the first part has committed
      calm = commits < CALM_N;
      if (!inst_val_i || inst_fire) begin
        if (inst_idx < n_inst && (calm || $urandom % 4 != 0)) begin
          inst_val_i = 1'b1;
          inst_i     = prog_word[inst_idx];
        end else begin
          inst_val_i = 1'b0;
          inst_i     = nop_word;
        end
      end
      if (!mngr2proc_val_i || mngr_fire) begin
        if (mngr_idx < n_mngr && (calm || $urandom % 3 != 0)) begin
          mngr2proc_val_i  = 1'b1;
          mngr2proc_data_i = mngr_q[mngr_idx];
        end else begin
          mngr2proc_val_i  = 1'b0;
          mngr2proc_data_i = '0;
        end
      end
      proc2mngr_rdy_i = calm || ($urandom % 3 != 0);
    end
  end

  //--------------------------------------------------------------------------
  // proc2mngr compare
  //--------------------------------------------------------------------------

  always @(posedge clk) begin
    if (!reset) begin
      // an offer without a transfer must hold
      if (held) begin
        check_equal("proc2mngr_val_o", 32'd1, {31'b0, proc2mngr_val_o});
        check_equal("proc2mngr_data_o", held_data, proc2mngr_data_o);
      end
      if (proc2mngr_val_o && proc2mngr_rdy_i) begin
        if (exp_idx >= n_exp || csrw_acc_q.size() == 0) begin
          fail_run("proc2mngr transfer beyond the expected sequence");
        end
        check_equal("proc2mngr_data_o", exp_q[exp_idx], proc2mngr_data_o);
        acc = csrw_acc_q.pop_front();
        if (acc >= 0) check_equal("proc2mngr latency", acc + 4, cycles);
        exp_idx++;
      end
      held      = proc2mngr_val_o && !proc2mngr_rdy_i;
      held_data = proc2mngr_data_o;
    end
  end

  // cycle count on the falling edge, stable for the rising edge readers
  always @(negedge clk) begin
    cycles++;
    if (cycles >= limit) fail_run("timeout, the program did not finish within the cycle limit");
  end

  initial begin
    clk              = 1'b0;
    reset            = 1'b1;
    inst_val_i       = 1'b0;
    mngr2proc_val_i  = 1'b0;
    mngr2proc_data_i = '0;
    proc2mngr_rdy_i  = 1'b0;
    void'($urandom(32'h3a8c));
    nop_word = encode(op_nop, 5'd0, 5'd0, 5'd0, '0);
    inst_i   = nop_word;
    build_program();
    run_model();
    n_inst = prog_op.size();
    n_mngr = mngr_q.size();
    n_exp  = exp_q.size();
    limit  = 20 * n_inst + 100;
    repeat (2) @(posedge clk);
    #1 reset = 1'b0;
    wait (exp_idx == n_exp && commits == n_inst);
    // a few idle cycles to catch late extra commits or transfers
    repeat (8) @(negedge clk);
    // drained pipeline takes input again and offers nothing
    if (inst_rdy_o && !mngr2proc_rdy_o && !proc2mngr_val_o && !commit_o &&
        mngr_idx == n_mngr) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      fail_run("pipeline not idle or mngr2proc data left over after the program drained");
    end
  end

endmodule

/* files.f */
+incdir+.
core_pkg.sv
core_alu.sv
core_regfile.sv
core_ctrl.sv
core_dpath.sv
core_top.sv
tb_core.sv
